// File: tb.f
uart_pkg.sv
uart_tx.sv
uart_rx.sv
uart_regs.sv
uart_periph.sv
tb_uart.sv

// File: Makefile
SRCS := $(shell cat tb.f)

all: run

obj_dir/Vtb_uart: tb.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/10ps --top-module tb_uart -f tb.f

run: obj_dir/Vtb_uart
	./obj_dir/Vtb_uart | tee /dev/stderr | grep -q '^TB PASSED$$'

clean:
	rm -rf obj_dir

.PHONY: all run clean

// File: tb_uart.sv
`timescale 1ns/10ps
`default_nettype none

module tb_uart;

   localparam logic [7:0] M_TX_BUSY   = 8'h01;
   localparam logic [7:0] M_RX_READY  = 8'h02;
   localparam logic [7:0] M_OVERRUN   = 8'h04;
   localparam logic [7:0] M_FRAME_ERR = 8'h08;
   localparam int         POLL_LIMIT  = 60 * uart_pkg::BIT_CYCLES;

   logic                 clk_i;
   logic                 rst_i;
   logic                 addr_i;
   logic                 wr_i;
   logic                 rd_i;
   logic [7:0]           wdata_i;
   uart_pkg::uart_word_u rdata_o;
   logic                 rxd_i;
   logic                 txd_o;

   logic        loop_en;                      // High routes txd_o back into rxd_i.
   logic        line_q;
   logic [15:0] lfsr_q;
   logic [7:0]  tx_expect[$];                 // Bytes written and not yet seen on txd_o.
   int          check_errs;
   int          other_errs;
   int          cycles = 0;

   assign rxd_i = loop_en ? txd_o : line_q;

   uart_periph i_dut
   (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .addr_i  (addr_i),
      .wr_i    (wr_i),
      .rd_i    (rd_i),
      .wdata_i (wdata_i),
      .rdata_o (rdata_o),
      .rxd_i   (rxd_i),
      .txd_o   (txd_o)
   );

   initial
   begin
      clk_i = 1'b0;
      forever #2 clk_i = ~clk_i;
   end

   always @(posedge clk_i)
   begin
      cycles++;
   end

   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      if (s[0])
         return (s >> 1) ^ 16'hB400;
      return s >> 1;
   endfunction

   function automatic logic [7:0] rand_byte();
      logic [7:0] b;
      for (int i = 0; i < 8; i++)
      begin
         lfsr_q = lfsr_next(lfsr_q);
         b[i]   = lfsr_q[0];
      end
      return b;
   endfunction

   function automatic uart_pkg::uart_word_u status_word(input logic ferr, input logic ovr,
                                                        input logic rdy, input logic busy);
      uart_pkg::uart_word_u w;
      w                  = '0;
      w.status.frame_err = ferr;
      w.status.overrun   = ovr;
      w.status.rx_ready  = rdy;
      w.status.tx_busy   = busy;
      return w;
   endfunction

   task automatic check_level(input string name, input logic got, input logic exp);
      if (got !== exp)
      begin
         check_errs++;
         $display("CHECK FAILED %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
      end
   endtask

   task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
      if (got !== exp)
      begin
         check_errs++;
         $display("CHECK FAILED %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
      end
   endtask

   task automatic check_status(input string name, input uart_pkg::uart_word_u got,
                               input uart_pkg::uart_word_u exp);
      if (got.status !== exp.status)
      begin
         check_errs++;
         $display("CHECK FAILED %s got 0x%h expected 0x%h at %0t",
                  name, got.status, exp.status, $time);
      end
   endtask

   // Host tasks start and end on a falling edge.
   task automatic write_byte(input logic [7:0] b);
      addr_i  = uart_pkg::ADDR_DATA;
      wdata_i = b;
      wr_i    = 1'b1;
      tx_expect.push_back(b);
      @(negedge clk_i);
      wr_i = 1'b0;
   endtask

   task automatic read_word(input logic addr, output uart_pkg::uart_word_u w);
      addr_i = addr;
      rd_i   = 1'b1;
      @(negedge clk_i);
      rd_i = 1'b0;
      w    = rdata_o;
   endtask

   task automatic wait_status(input logic [7:0] mask, input logic [7:0] val, input string what,
                              output uart_pkg::uart_word_u w);
      int polls;
      polls = 0;
      read_word(uart_pkg::ADDR_STATUS, w);
      while (((w.data & mask) !== val) && (polls < POLL_LIMIT))
      begin
         read_word(uart_pkg::ADDR_STATUS, w);
         polls++;
      end
      if ((w.data & mask) !== val)
      begin
         other_errs++;
         $display("Timed out waiting for %s at %0t", what, $time);
      end
   endtask

   task automatic send_frame(input logic [7:0] b, input logic stop);
      logic [9:0] bits;
      bits = {stop, b, 1'b0};
      for (int i = 0; i < 10; i++)
      begin
         line_q = bits[i];
         repeat (uart_pkg::BIT_CYCLES) @(negedge clk_i);
      end
      line_q = 1'b1;
      repeat (2 * uart_pkg::BIT_CYCLES) @(negedge clk_i);
   endtask

   task automatic expect_tx_drained();
      if (tx_expect.size() != 0)
      begin
         other_errs++;
         $display("%0d written bytes never appeared on txd_o", tx_expect.size());
         tx_expect.delete();
      end
   endtask

   // Decodes txd_o at mid-bit after each falling start edge.
   initial
   begin : txd_monitor
      logic [7:0] got;
      @(negedge rst_i);
      forever
      begin
         @(negedge clk_i);
         if (txd_o === 1'b0)
         begin
            repeat (uart_pkg::HALF_BIT - 1) @(negedge clk_i);
            check_level("txd_o start bit", txd_o, 1'b0);
            for (int i = 0; i < 8; i++)
            begin
               repeat (uart_pkg::BIT_CYCLES) @(negedge clk_i);
               got[i] = txd_o;                // LSB first.
            end
            repeat (uart_pkg::BIT_CYCLES) @(negedge clk_i);
            check_level("txd_o stop bit", txd_o, 1'b1);
            if (tx_expect.size() == 0)
            begin
               other_errs++;
               $display("Frame on txd_o with no byte written at %0t", $time);
            end
            else
               check_byte("txd_o data", got, tx_expect.pop_front());
         end
      end
   end

   initial
   begin : main
      uart_pkg::uart_word_u w;
      logic [7:0]           a;
      logic [7:0]           b;
      int                   t0;
      rst_i      = 1'b1;
      addr_i     = 1'b0;
      wr_i       = 1'b0;
      rd_i       = 1'b0;
      wdata_i    = 8'h00;
      loop_en    = 1'b0;
      line_q     = 1'b1;
      lfsr_q     = 16'd31141;
      check_errs = 0;
      other_errs = 0;
      repeat (16) @(posedge clk_i);
      @(negedge clk_i);
      rst_i = 1'b0;

      check_byte("rdata_o after reset", rdata_o.data, 8'h00);
      for (int i = 0; i < 2 * uart_pkg::BIT_CYCLES; i++)
      begin
         check_level("txd_o idle", txd_o, 1'b1);
         @(negedge clk_i);
      end
      read_word(uart_pkg::ADDR_STATUS, w);
      check_status("status after reset", w, status_word(1'b0, 1'b0, 1'b0, 1'b0));

      for (int n = 0; n < 40; n++)
      begin
         wait_status(M_TX_BUSY, 8'h00, "tx_busy low", w);
         write_byte(rand_byte());
      end
      wait_status(M_TX_BUSY, 8'h00, "tx_busy low", w);
      expect_tx_drained();

      loop_en = 1'b1;
      for (int n = 0; n < 8; n++)
      begin
         a = rand_byte();
         write_byte(a);
         wait_status(M_RX_READY, M_RX_READY, "rx_ready", w);
         check_status("status with byte ready", w, status_word(1'b0, 1'b0, 1'b1, 1'b0));
         read_word(uart_pkg::ADDR_DATA, w);
         check_byte("looped back byte", w.data, a);
         read_word(uart_pkg::ADDR_STATUS, w);
         check_status("status after data read", w, status_word(1'b0, 1'b0, 1'b0, 1'b0));
      end

      loop_en = 1'b0;
      a  = rand_byte();
      b  = rand_byte();
      t0 = cycles;
      write_byte(a);
      write_byte(b);                          // Waits in the buffer behind the first frame.
      wait_status(M_TX_BUSY, 8'h00, "end of two buffered frames", w);
      if ((cycles - t0) < 20 * uart_pkg::BIT_CYCLES)
      begin
         other_errs++;
         $display("tx_busy dropped %0d cycles after two writes, before both frames ended",
                  cycles - t0);
      end
      expect_tx_drained();

      loop_en = 1'b1;
      a = rand_byte();
      b = rand_byte();
      write_byte(a);
      write_byte(b);
      wait_status(M_OVERRUN, M_OVERRUN, "overrun", w);
      check_status("status on overrun", w, status_word(1'b0, 1'b1, 1'b1, 1'b0));
      read_word(uart_pkg::ADDR_DATA, w);
      check_byte("byte kept on overrun", w.data, b);
      read_word(uart_pkg::ADDR_STATUS, w);
      check_status("status after overrun read", w, status_word(1'b0, 1'b0, 1'b0, 1'b0));

      loop_en = 1'b0;
      send_frame(rand_byte(), 1'b0);          // Stop bit low.
      wait_status(M_FRAME_ERR, M_FRAME_ERR, "frame_err", w);
      check_status("status on frame error", w, status_word(1'b1, 1'b0, 1'b0, 1'b0));
      read_word(uart_pkg::ADDR_STATUS, w);
      check_status("status after frame error read", w, status_word(1'b0, 1'b0, 1'b0, 1'b0));
      b = rand_byte();
      send_frame(b, 1'b1);
      wait_status(M_RX_READY, M_RX_READY, "rx_ready after good frame", w);
      check_status("status after good frame", w, status_word(1'b0, 1'b0, 1'b1, 1'b0));
      read_word(uart_pkg::ADDR_DATA, w);
      check_byte("byte after frame error", w.data, b);
      expect_tx_drained();

      $display("Summary: %0d value mismatches, %0d other errors", check_errs, other_errs);
      if ((check_errs == 0) && (other_errs == 0))
         $display("TB PASSED");
      else
         $display("TB FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// File: uart_periph.sv
`timescale 1ns/10ps
`default_nettype none

module uart_periph
(
   input  wire                  clk_i,
   input  wire                  rst_i,
   input  wire                  addr_i,
   input  wire                  wr_i,
   input  wire                  rd_i,
   input  wire  [7:0]           wdata_i,
   output uart_pkg::uart_word_u rdata_o,
   input  wire                  rxd_i,
   output logic                 txd_o
);

   logic       tx_load;
   logic [7:0] tx_byte;
   logic       tx_busy;
   logic       rx_done;
   logic [7:0] rx_byte;
   logic       frame_err;

   uart_regs i_regs
   (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .addr_i      (addr_i),
      .wr_i        (wr_i),
      .rd_i        (rd_i),
      .wdata_i     (wdata_i),
      .tx_busy_i   (tx_busy),
      .rx_done_i   (rx_done),
      .rx_byte_i   (rx_byte),
      .frame_err_i (frame_err),
      .tx_load_o   (tx_load),
      .tx_byte_o   (tx_byte),
      .rdata_o     (rdata_o)
   );

   uart_tx i_tx
   (
      .clk_i     (clk_i),
      .rst_i     (rst_i),
      .tx_load_i (tx_load),
      .tx_byte_i (tx_byte),
      .tx_busy_o (tx_busy),
      .txd_o     (txd_o)
   );

   uart_rx i_rx
   (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .rxd_i       (rxd_i),
      .rx_done_o   (rx_done),
      .rx_byte_o   (rx_byte),
      .frame_err_o (frame_err)
   );

endmodule

`default_nettype wire

// File: uart_regs.sv
`timescale 1ns/10ps
`default_nettype none

module uart_regs
(
   input  wire                  clk_i,
   input  wire                  rst_i,
   input  wire                  addr_i,
   input  wire                  wr_i,
   input  wire                  rd_i,
   input  wire  [7:0]           wdata_i,
   input  wire                  tx_busy_i,
   input  wire                  rx_done_i,
   input  wire  [7:0]           rx_byte_i,
   input  wire                  frame_err_i,
   output logic                 tx_load_o,
   output logic [7:0]           tx_byte_o,
   output uart_pkg::uart_word_u rdata_o
);

   logic                 rd_data;
   logic                 rd_status;
   logic [7:0]           rx_data;
   logic                 rx_ready;
   logic                 overrun;
   logic                 frame_err;
   uart_pkg::uart_word_u word_nxt;

   assign tx_load_o = wr_i && (addr_i == uart_pkg::ADDR_DATA);
   assign tx_byte_o = wdata_i;
   assign rd_data   = rd_i && (addr_i == uart_pkg::ADDR_DATA);
   assign rd_status = rd_i && (addr_i == uart_pkg::ADDR_STATUS);

   always_ff @(posedge clk_i)
   begin
      if (rx_done_i)
      begin
         rx_data <= rx_byte_i;                // A new byte replaces an unread one.
      end
   end

   // Sticky flags. A set in the same cycle as a clear wins.
   always_ff @(posedge clk_i or posedge rst_i)
   begin
      if (rst_i)
      begin
         rx_ready  <= 1'b0;
         overrun   <= 1'b0;
         frame_err <= 1'b0;
      end
      else
      begin
         if (rx_done_i)
            rx_ready <= 1'b1;
         else if (rd_data)
            rx_ready <= 1'b0;
         if (rx_done_i && rx_ready && !rd_data)
            overrun <= 1'b1;                  // The old byte was never read.
         else if (rd_status)
            overrun <= 1'b0;
         if (frame_err_i)
            frame_err <= 1'b1;
         else if (rd_status)
            frame_err <= 1'b0;
      end
   end

   always_comb
   begin
      word_nxt = '0;
      if (addr_i == uart_pkg::ADDR_DATA)
      begin
         word_nxt.data = rx_data;
      end
      else
      begin
         word_nxt.status.frame_err = frame_err;
         word_nxt.status.overrun   = overrun;
         word_nxt.status.rx_ready  = rx_ready;
         word_nxt.status.tx_busy   = tx_busy_i;
      end
   end

   always_ff @(posedge clk_i or posedge rst_i)
   begin
      if (rst_i)
         rdata_o <= '0;
      else if (rd_i)
         rdata_o <= word_nxt;                 // Holds until the next read.
   end

   a_no_wr_rd: assert property (@(posedge clk_i) disable iff (rst_i) !(wr_i && rd_i))
      else $error("uart_regs: write and read strobes together");

   a_rx_excl: assert property (@(posedge clk_i) disable iff (rst_i)
      !(rx_done_i && frame_err_i))
      else $error("uart_regs: byte and frame error in one cycle");

endmodule

`default_nettype wire

// File: uart_rx.sv
`timescale 1ns/10ps
`default_nettype none

module uart_rx
(
   input  wire        clk_i,
   input  wire        rst_i,
   input  wire        rxd_i,
   output logic       rx_done_o,
   output logic [7:0] rx_byte_o,
   output logic       frame_err_o
);

   logic                       sync_q1;
   logic                       sync_q2;
   logic [3:0]                 bit_cnt;     // 0 hunt, 1 start check, 2..9 data, 10 stop.
   logic [uart_pkg::CNT_W-1:0] cyc_cnt;
   logic [7:0]                 shift_q;
   logic                       done_pend;
   logic                       sample;

   assign sample = (cyc_cnt == '0);

   always_ff @(posedge clk_i or posedge rst_i)
   begin
      if (rst_i)
      begin
         sync_q1 <= 1'b1;
         sync_q2 <= 1'b1;
      end
      else
      begin
         sync_q1 <= rxd_i;
         sync_q2 <= sync_q1;
      end
   end

   always_ff @(posedge clk_i or posedge rst_i)
   begin
      if (rst_i)
      begin
         bit_cnt     <= 4'd0;
         cyc_cnt     <= '0;
         done_pend   <= 1'b0;
         rx_done_o   <= 1'b0;
         frame_err_o <= 1'b0;
      end
      else
      begin
         rx_done_o   <= 1'b0;
         frame_err_o <= 1'b0;
         if (!sample)
         begin
            cyc_cnt <= cyc_cnt - 1'b1;
         end
         else
         begin
            case (bit_cnt)
               4'd0:
               begin
                  rx_done_o <= done_pend;     // Reported at the end of the stop bit.
                  done_pend <= 1'b0;
                  if (!sync_q2)
                  begin
                     bit_cnt <= 4'd1;
                     cyc_cnt <= uart_pkg::CYC_HALF;
                  end
               end
               4'd1:
               begin
                  if (!sync_q2)
                  begin
                     bit_cnt <= 4'd2;
                     cyc_cnt <= uart_pkg::CYC_FULL;
                  end
                  else
                  begin
                     bit_cnt <= 4'd0;         // Glitch, not a start bit.
                  end
               end
               4'd10:
               begin
                  bit_cnt <= 4'd0;
                  if (sync_q2)
                  begin
                     done_pend <= 1'b1;
                     cyc_cnt   <= uart_pkg::CYC_HALF;
                  end
                  else
                  begin
                     frame_err_o <= 1'b1;
                     cyc_cnt     <= uart_pkg::CYC_FULL;  // Hold off one bit before hunting.
                  end
               end
               default:
               begin
                  bit_cnt <= bit_cnt + 4'd1;
                  cyc_cnt <= uart_pkg::CYC_FULL;
               end
            endcase
         end
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (sample && (bit_cnt >= 4'd2) && (bit_cnt <= 4'd9))
      begin
         shift_q <= {sync_q2, shift_q[7:1]};
      end
      if (sample && (bit_cnt == 4'd10) && sync_q2)
      begin
         rx_byte_o <= shift_q;
      end
   end

   a_bit_range: assert property (@(posedge clk_i) disable iff (rst_i) bit_cnt <= 4'd10)
      else $error("uart_rx: bit counter out of range");

endmodule

`default_nettype wire

// File: uart_tx.sv
`timescale 1ns/10ps
`default_nettype none

module uart_tx
(
   input  wire        clk_i,
   input  wire        rst_i,
   input  wire        tx_load_i,
   input  wire  [7:0] tx_byte_i,
   output logic       tx_busy_o,
   output logic       txd_o
);

   logic [7:0]                 tx_buf;
   logic                       buf_full;
   logic [7:0]                 shift_q;
   logic [3:0]                 bit_cnt;     // 0 idle, 1 start, 2..9 data, 10 stop.
   logic [uart_pkg::CNT_W-1:0] cyc_cnt;
   logic                       bit_end;
   logic                       start;

   assign bit_end = (cyc_cnt == '0);
   // A waiting byte goes out from idle or right behind the previous stop bit.
   assign start   = buf_full && bit_end && ((bit_cnt == 4'd0) || (bit_cnt == 4'd10));

   assign tx_busy_o = buf_full || (bit_cnt != 4'd0);

   always_ff @(posedge clk_i or posedge rst_i)
   begin
      if (rst_i)
      begin
         buf_full <= 1'b0;
      end
      else if (tx_load_i)
      begin
         buf_full <= 1'b1;                    // A load in the start cycle refills it.
      end
      else if (start)
      begin
         buf_full <= 1'b0;
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (tx_load_i)
      begin
         tx_buf <= tx_byte_i;                 // Overwrites a byte not yet sent.
      end
      if (start)
      begin
         shift_q <= tx_buf;
      end
      else if (bit_end && (bit_cnt != 4'd0) && (bit_cnt < 4'd9))
      begin
         shift_q <= {1'b0, shift_q[7:1]};
      end
   end

   always_ff @(posedge clk_i or posedge rst_i)
   begin
      if (rst_i)
      begin
         bit_cnt <= 4'd0;
         cyc_cnt <= '0;
         txd_o   <= 1'b1;
      end
      else if (!bit_end)
      begin
         cyc_cnt <= cyc_cnt - 1'b1;
      end
      else if (start)
      begin
         txd_o   <= 1'b0;
         bit_cnt <= 4'd1;
         cyc_cnt <= uart_pkg::CYC_FULL;
      end
      else if (bit_cnt == 4'd10)
      begin
         bit_cnt <= 4'd0;                     // Line is already high.
      end
      else if (bit_cnt == 4'd9)
      begin
         txd_o   <= 1'b1;
         bit_cnt <= 4'd10;
         cyc_cnt <= uart_pkg::CYC_FULL;
      end
      else if (bit_cnt != 4'd0)
      begin
         txd_o   <= shift_q[0];               // LSB first.
         bit_cnt <= bit_cnt + 4'd1;
         cyc_cnt <= uart_pkg::CYC_FULL;
      end
   end

   a_idle_high: assert property (@(posedge clk_i) disable iff (rst_i)
      (bit_cnt == 4'd0) |-> txd_o)
      else $error("uart_tx: txd_o low while idle");

endmodule

`default_nettype wire

// File: uart_pkg.sv
`default_nettype none

package uart_pkg;

   localparam int BIT_CYCLES = 8;                // Clock cycles in one serial bit.
   localparam int HALF_BIT   = BIT_CYCLES / 2;   // Start edge to first sample.
   localparam int CNT_W      = $clog2(BIT_CYCLES);

   // Reload values for the down counters, which count a bit as N-1 down to 0.
   localparam logic [CNT_W-1:0] CYC_FULL = CNT_W'(BIT_CYCLES - 1);
   localparam logic [CNT_W-1:0] CYC_HALF = CNT_W'(HALF_BIT - 1);

   localparam logic ADDR_DATA   = 1'b0;
   localparam logic ADDR_STATUS = 1'b1;

   // One read word, seen as the received byte or as the status layout.
   typedef union packed
   {
      logic [7:0] data;
      struct packed
      {
         logic [3:0] rsvd;          // Always read as zero.
         logic       frame_err;
         logic       overrun;
         logic       rx_ready;
         logic       tx_busy;
      } status;
   } uart_word_u;

endpackage

`default_nettype wire
